// File: Bender.yml
package:
  name: axi_mem_burst

sources:
  # Synthesizable design, packages first.
  - target: any(simulation, synthesis)
    files:
      - hw/axi_port_pkg.sv
      - hw/bank_pkg.sv
      - hw/burst_unroll.sv
      - hw/rw_arbiter.sv
      - hw/resp_tracker.sv
      - hw/bank_split.sv
      - hw/axi_mem_top.sv

  # Testbench and bank models, top is tb_axi_mem_top.
  - target: test
    files:
      - bench/bank_model.sv
      - bench/tb_axi_mem_top.sv

// File: bench/bank_model.sv
/*
 * Behavioral bank memories for simulation.
 * Grants follow an enable vector from the testbench, and every
 * granted request is answered on the following cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module bank_model
  import axi_port_pkg::*, bank_pkg::*;
(
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire  [NUM_BANKS-1:0]                 gnt_en_i,
  input  wire  [NUM_BANKS-1:0]                 bank_req_i,
  output logic [NUM_BANKS-1:0]                 bank_gnt_o,
  input  wire  [NUM_BANKS-1:0][ADDR_WIDTH-1:0] bank_addr_i,
  input  wire  bank_data_t [NUM_BANKS-1:0]     bank_wdata_i,
  input  wire  bank_strb_t [NUM_BANKS-1:0]     bank_strb_i,
  input  wire  [NUM_BANKS-1:0]                 bank_we_i,
  output logic [NUM_BANKS-1:0]                 bank_rvalid_o,
  output bank_data_t [NUM_BANKS-1:0]           bank_rdata_o
);

  // One byte array shared by all banks, indexed by byte address.
  logic [7:0] mem [2**ADDR_WIDTH];

  // Start-up contents depend on every address bit.
  initial begin
    for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h96;
    end
  end

  // Grant gaps come from the testbench.
  assign bank_gnt_o = gnt_en_i;

  always @(posedge clk_i) begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (reset_i) begin
        bank_rvalid_o[i] <= 1'b0;
      end else begin
        // One response per grant, writes included.
        bank_rvalid_o[i] <= bank_req_i[i] & bank_gnt_o[i];
        if (bank_req_i[i] && bank_gnt_o[i]) begin
          for (int b = 0; b < BANK_BYTES; b++) begin
            bank_rdata_o[i][8*b +: 8] <= mem[bank_addr_i[i] + ADDR_WIDTH'(b)];
            if (bank_we_i[i] && bank_strb_i[i][b]) begin
              mem[bank_addr_i[i] + ADDR_WIDTH'(b)] <= bank_wdata_i[i][8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_axi_mem_top.sv
/*
 * Testbench for the burst slave. Issues random write and read bursts,
 * keeps a byte reference memory and checks B and R with assertions
 * under random ready and grant gaps.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem_top
  import axi_port_pkg::*, bank_pkg::*;
();

  localparam int TIMEOUT = 1000;

  logic clk, reset;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last, busy;
  logic [ADDR_WIDTH-1:0] aw_addr, ar_addr;
  logic [LEN_WIDTH-1:0]  aw_len, ar_len;
  logic [ID_WIDTH-1:0]   aw_id, ar_id, b_id, r_id;
  logic [DATA_WIDTH-1:0] w_data, r_data;
  logic [STRB_WIDTH-1:0] w_strb;
  resp_e                 b_resp, r_resp;
  // Bank side.
  logic [NUM_BANKS-1:0]                 bank_req, bank_gnt, bank_we, bank_rvalid, gnt_en;
  logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0] bank_addr;
  bank_data_t [NUM_BANKS-1:0]           bank_wdata, bank_rdata;
  bank_strb_t [NUM_BANKS-1:0]           bank_strb;

  // Reference memory and expected responses in arrival order.
  logic [7:0]            ref_mem [2**ADDR_WIDTH];
  logic [ID_WIDTH-1:0]   exp_b_id [$];
  logic [DATA_WIDTH-1:0] exp_r_data [$];
  logic [ID_WIDTH-1:0]   exp_r_id [$];
  logic                  exp_r_last [$];
  // Previous sample of a stalled response.
  logic                  r_hold, b_hold, r_last_prev;
  logic [DATA_WIDTH-1:0] r_data_prev;
  logic [ID_WIDTH-1:0]   r_id_prev, b_id_prev;

  axi_mem_top uut (
    .clk_i(clk), .reset_i(reset),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .aw_len_i(aw_len), .aw_id_i(aw_id),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_id_o(b_id), .b_resp_o(b_resp),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .ar_len_i(ar_len), .ar_id_i(ar_id),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_id_o(r_id),
    .r_last_o(r_last), .r_resp_o(r_resp),
    .bank_req_o(bank_req), .bank_gnt_i(bank_gnt), .bank_addr_o(bank_addr),
    .bank_wdata_o(bank_wdata), .bank_strb_o(bank_strb), .bank_we_o(bank_we),
    .bank_rvalid_i(bank_rvalid), .bank_rdata_i(bank_rdata), .busy_o(busy)
  );

  bank_model u_banks (
    .clk_i(clk), .reset_i(reset), .gnt_en_i(gnt_en),
    .bank_req_i(bank_req), .bank_gnt_o(bank_gnt), .bank_addr_i(bank_addr),
    .bank_wdata_i(bank_wdata), .bank_strb_i(bank_strb), .bank_we_i(bank_we),
    .bank_rvalid_o(bank_rvalid), .bank_rdata_o(bank_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Same start-up contents as the bank memories.
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'h96;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] ref_word(input logic [ADDR_WIDTH-1:0] a);
    logic [DATA_WIDTH-1:0] w;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      w[8*b +: 8] = ref_mem[a + ADDR_WIDTH'(b)];
    end
    return w;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_idle(input string when);
    assert (!b_valid && !r_valid && bank_req == '0 && !busy)
      else abort_run($sformatf("Fail at %0t: outputs not idle %s", $time, when));
  endtask

  // AW goes out with the first W beat, then one W beat per word.
  task automatic write_burst(input logic [ADDR_WIDTH-1:0] addr, input int len,
                             input logic [ID_WIDTH-1:0] id, input bit partial);
    logic [ADDR_WIDTH-1:0] base;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    int beat;
    int n;
    base = addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
    exp_b_id.push_back(id);
    for (beat = 0; beat <= len; beat++) begin
      data = $urandom;
      strb = partial ? STRB_WIDTH'($urandom) : '1;
      @(posedge clk);
      aw_valid <= (beat == 0);
      aw_addr  <= addr;
      aw_len   <= LEN_WIDTH'(len);
      aw_id    <= id;
      w_valid  <= 1'b1;
      w_data   <= data;
      w_strb   <= strb;
      for (n = 0; n < TIMEOUT; n++) begin
        @(negedge clk);
        if (w_ready) break;
      end
      if (n == TIMEOUT) abort_run("Timed out waiting for w_ready");
      if (beat == 0) begin
        assert (aw_ready) else abort_run($sformatf("Fail at %0t: AW not taken", $time));
      end
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) ref_mem[base + ADDR_WIDTH'(beat * WORD_BYTES + b)] = data[8*b +: 8];
      end
    end
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
  endtask

  // Expected beats are taken from the reference memory at issue time.
  task automatic read_burst(input logic [ADDR_WIDTH-1:0] addr, input int len,
                            input logic [ID_WIDTH-1:0] id);
    logic [ADDR_WIDTH-1:0] base;
    int beat;
    int n;
    base = addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
    for (beat = 0; beat <= len; beat++) begin
      exp_r_data.push_back(ref_word(base + ADDR_WIDTH'(beat * WORD_BYTES)));
      exp_r_id.push_back(id);
      exp_r_last.push_back(beat == len);
    end
    @(posedge clk);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    ar_len   <= LEN_WIDTH'(len);
    ar_id    <= id;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (ar_ready) break;
    end
    if (n == TIMEOUT) abort_run("Timed out waiting for ar_ready");
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (exp_b_id.size() == 0 && exp_r_data.size() == 0) break;
      // Responses still owed, so the slave must report busy.
      assert (busy)
        else abort_run($sformatf("Fail at %0t: busy low with responses owed", $time));
    end
    if (n == TIMEOUT) abort_run("Timed out waiting for outstanding B and R responses");
    @(negedge clk);
    check_idle("after drain");
  endtask

  // Random ready and grant gaps.
  always @(posedge clk) begin
    r_ready <= ($urandom % 4) != 0;
    b_ready <= ($urandom % 3) != 0;
    gnt_en  <= NUM_BANKS'($urandom);
  end

  // Response checks, sampled mid-cycle where outputs are settled.
  always @(negedge clk) begin
    if (reset) begin
      r_hold = 1'b0;
      b_hold = 1'b0;
    end else begin
      if (r_hold) begin
        assert (r_valid && r_data == r_data_prev && r_id == r_id_prev && r_last == r_last_prev)
          else abort_run($sformatf("Fail at %0t: R changed while stalled", $time));
      end
      if (b_hold) begin
        assert (b_valid && b_id == b_id_prev)
          else abort_run($sformatf("Fail at %0t: B changed while stalled", $time));
      end
      if (r_valid || b_valid) begin
        assert (busy) else abort_run($sformatf("Fail at %0t: busy low", $time));
      end
      if (r_valid && r_ready) begin
        assert (exp_r_data.size() != 0) else abort_run("R beat arrived with no read outstanding");
        assert (r_data == exp_r_data[0] && r_id == exp_r_id[0] && r_last == exp_r_last[0] &&
                r_resp == RESP_OKAY)
          else abort_run($sformatf(
                 "Fail at %0t: R got %h id %h last %b, expected %h id %h last %b",
                 $time, r_data, r_id, r_last, exp_r_data[0], exp_r_id[0], exp_r_last[0]));
        void'(exp_r_data.pop_front());
        void'(exp_r_id.pop_front());
        void'(exp_r_last.pop_front());
      end
      if (b_valid && b_ready) begin
        assert (exp_b_id.size() != 0) else abort_run("B arrived with no write outstanding");
        assert (b_id == exp_b_id[0] && b_resp == RESP_OKAY)
          else abort_run($sformatf("Fail at %0t: B got id %h resp %h, expected id %h",
                                   $time, b_id, b_resp, exp_b_id[0]));
        void'(exp_b_id.pop_front());
      end
      r_hold      = r_valid && !r_ready;
      b_hold      = b_valid && !b_ready;
      r_data_prev = r_data;
      r_id_prev   = r_id;
      r_last_prev = r_last;
      b_id_prev   = b_id;
    end
  end

  initial begin
    logic [ADDR_WIDTH-1:0] addr, raddr;
    int len, rlen, i, a;
    void'($urandom(32'h4e25));
    reset    = 1'b1;
    aw_valid = 1'b0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_id    = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    ar_len   = '0;
    ar_id    = '0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    gnt_en   = '0;
    for (a = 0; a < 2**ADDR_WIDTH; a++) ref_mem[a] = fill_byte(a);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle("after reset");

    // Full-strobe write, then read back the same words.
    for (i = 0; i < 6; i++) begin
      addr = ADDR_WIDTH'($urandom);
      len  = $urandom % 8;
      write_burst(addr, len, ID_WIDTH'(i), 1'b0);
      wait_drain();
      read_burst(addr, len, ID_WIDTH'(i + 8));
      wait_drain();
    end

    // Partial strobes keep the other bytes.
    for (i = 0; i < 6; i++) begin
      addr = ADDR_WIDTH'($urandom);
      len  = $urandom % 8;
      write_burst(addr, len, ID_WIDTH'(i), 1'b1);
      wait_drain();
      read_burst(addr, len, ID_WIDTH'(i + 4));
      wait_drain();
    end

    // Reads and writes at once, on disjoint halves of the space.
    for (i = 0; i < 8; i++) begin
      addr  = ADDR_WIDTH'($urandom) & 16'h3fff;
      raddr = (ADDR_WIDTH'($urandom) & 16'h3fff) | 16'h8000;
      len   = $urandom % 8;
      rlen  = $urandom % 8;
      fork
        write_burst(addr, len, ID_WIDTH'(i), 1'b1);
        read_burst(raddr, rlen, ID_WIDTH'(i + 8));
      join
      wait_drain();
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/axi_mem_top.sv
/*
 * Burst slave that turns AXI-style read and write bursts into
 * single-beat requests on NUM_BANKS parallel memory banks.
 */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_top
  import axi_port_pkg::*, bank_pkg::*;
(
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  aw_valid_i,
  output logic                                 aw_ready_o,
  input  wire  [ADDR_WIDTH-1:0]                aw_addr_i,
  input  wire  [LEN_WIDTH-1:0]                 aw_len_i,
  input  wire  [ID_WIDTH-1:0]                  aw_id_i,
  input  wire                                  w_valid_i,
  output logic                                 w_ready_o,
  input  wire  [DATA_WIDTH-1:0]                w_data_i,
  input  wire  [STRB_WIDTH-1:0]                w_strb_i,
  output logic                                 b_valid_o,
  input  wire                                  b_ready_i,
  output logic [ID_WIDTH-1:0]                  b_id_o,
  output resp_e                                b_resp_o,
  input  wire                                  ar_valid_i,
  output logic                                 ar_ready_o,
  input  wire  [ADDR_WIDTH-1:0]                ar_addr_i,
  input  wire  [LEN_WIDTH-1:0]                 ar_len_i,
  input  wire  [ID_WIDTH-1:0]                  ar_id_i,
  output logic                                 r_valid_o,
  input  wire                                  r_ready_i,
  output logic [DATA_WIDTH-1:0]                r_data_o,
  output logic [ID_WIDTH-1:0]                  r_id_o,
  output logic                                 r_last_o,
  output resp_e                                r_resp_o,
  output logic [NUM_BANKS-1:0]                 bank_req_o,
  input  wire  [NUM_BANKS-1:0]                 bank_gnt_i,
  output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0] bank_addr_o,
  output bank_data_t [NUM_BANKS-1:0]           bank_wdata_o,
  output bank_strb_t [NUM_BANKS-1:0]           bank_strb_o,
  output logic [NUM_BANKS-1:0]                 bank_we_o,
  input  wire  [NUM_BANKS-1:0]                 bank_rvalid_i,
  input  wire  bank_data_t [NUM_BANKS-1:0]     bank_rdata_i,
  output logic                                 busy_o
);

  // Beat streams out of the burst units.
  logic                  rd_valid, rd_ready, rd_last, rd_in_burst;
  logic                  wr_valid, wr_ready, wr_last, wr_in_burst;
  logic [ADDR_WIDTH-1:0] rd_addr, wr_addr, arb_addr;
  logic [ID_WIDTH-1:0]   rd_id, wr_id, arb_id;
  // Arbitrated stream, fork readiness and memory response.
  logic                  arb_valid, arb_ready, arb_last, arb_write;
  logic                  trk_ready, split_ready, mem_rvalid, trk_busy;
  logic [DATA_WIDTH-1:0] mem_rdata;

  burst_unroll #(.WRITE_SIDE(1'b0)) u_rd_unroll (
    .clk_i, .reset_i,
    .ax_valid_i(ar_valid_i), .ax_ready_o(ar_ready_o), .ax_addr_i(ar_addr_i),
    .ax_len_i(ar_len_i), .ax_id_i(ar_id_i), .w_valid_i(),
    .beat_valid_o(rd_valid), .beat_ready_i(rd_ready), .beat_addr_o(rd_addr),
    .beat_id_o(rd_id), .beat_last_o(rd_last), .in_burst_o(rd_in_burst)
  );

  burst_unroll #(.WRITE_SIDE(1'b1)) u_wr_unroll (
    .clk_i, .reset_i,
    .ax_valid_i(aw_valid_i), .ax_ready_o(aw_ready_o), .ax_addr_i(aw_addr_i),
    .ax_len_i(aw_len_i), .ax_id_i(aw_id_i), .w_valid_i(w_valid_i),
    .beat_valid_o(wr_valid), .beat_ready_i(wr_ready), .beat_addr_o(wr_addr),
    .beat_id_o(wr_id), .beat_last_o(wr_last), .in_burst_o(wr_in_burst)
  );

  rw_arbiter u_arbiter (
    .clk_i, .reset_i,
    .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_addr_i(rd_addr),
    .rd_id_i(rd_id), .rd_last_i(rd_last), .rd_in_burst_i(rd_in_burst),
    .wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_addr_i(wr_addr),
    .wr_id_i(wr_id), .wr_last_i(wr_last), .wr_in_burst_i(wr_in_burst),
    .out_valid_o(arb_valid), .out_ready_i(arb_ready), .out_addr_o(arb_addr),
    .out_id_o(arb_id), .out_last_o(arb_last), .out_write_o(arb_write)
  );

  // Every branch of the three-way fork sees the same transfer.
  assign arb_ready = trk_ready & split_ready;
  // W data is consumed with its write beat.
  assign w_ready_o = wr_valid & wr_ready;

  resp_tracker u_tracker (
    .clk_i, .reset_i,
    .enq_valid_i(arb_valid & split_ready), .enq_ready_o(trk_ready),
    .enq_id_i(arb_id), .enq_last_i(arb_last), .enq_write_i(arb_write),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
    .b_valid_o, .b_ready_i, .b_id_o, .b_resp_o,
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o, .r_resp_o,
    .busy_o(trk_busy)
  );

  bank_split u_split (
    .clk_i, .reset_i,
    .req_valid_i(arb_valid & trk_ready), .req_ready_o(split_ready),
    .req_addr_i(arb_addr), .req_wdata_i(w_data_i), .req_strb_i(w_strb_i),
    .req_we_i(arb_write), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata),
    .bank_req_o, .bank_gnt_i, .bank_addr_o, .bank_wdata_o, .bank_strb_o,
    .bank_we_o, .bank_rvalid_i, .bank_rdata_i
  );

  // Pending requests, running bursts or beats in flight.
  assign busy_o = aw_valid_i | w_valid_i | ar_valid_i | rd_in_burst | wr_in_burst | trk_busy;

endmodule

`default_nettype wire

// File: hw/axi_port_pkg.sv
/*
 * Slave port definitions for the burst-to-memory bridge.
 * Modules that handle AXI channel fields import this package.
 */
`default_nettype none

package axi_port_pkg;

  // Byte address, beat and ID widths.
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;

  // A burst carries len+1 beats.
  localparam int LEN_WIDTH  = 8;

  // Every beat is full width, so the address steps by one word.
  localparam int WORD_BYTES = DATA_WIDTH / 8;

  // Response codes.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Burst unit state.
  typedef enum logic {
    IDLE  = 1'b0,
    BURST = 1'b1
  } burst_state_e;

endpackage

`default_nettype wire

// File: hw/bank_pkg.sv
/*
 * Bank memory geometry and response buffering limits.
 * Modules on the memory side import this package.
 */
`default_nettype none

package bank_pkg;

  import axi_port_pkg::*;

  // A beat is spread evenly over the banks.
  localparam int NUM_BANKS   = 2;
  localparam int BANK_WIDTH  = DATA_WIDTH / NUM_BANKS;
  localparam int BANK_BYTES  = BANK_WIDTH / 8;

  // Outstanding beats, and metadata FIFO depth.
  localparam int BUF_DEPTH   = 2;
  localparam int TRACK_DEPTH = BUF_DEPTH + 1;

  // Pointer and occupancy widths.
  localparam int BUF_PTR_W   = $clog2(BUF_DEPTH);
  localparam int BUF_CNT_W   = $clog2(BUF_DEPTH + 1);
  localparam int TRACK_PTR_W = $clog2(TRACK_DEPTH);
  localparam int TRACK_CNT_W = $clog2(TRACK_DEPTH + 1);

  typedef logic [BANK_WIDTH-1:0] bank_data_t;
  typedef logic [BANK_BYTES-1:0] bank_strb_t;

endpackage

`default_nettype wire

// File: hw/bank_split.sv
/*
 * Spreads one full-width memory request over the narrow banks.
 * Each bank has fall-through registers for request and response,
 * and the joined response is valid once every bank has answered.
 */
`timescale 1ns/100ps
`default_nettype none

module bank_split
  import axi_port_pkg::*, bank_pkg::*;
(
  input  wire                                   clk_i,
  input  wire                                   reset_i,
  input  wire                                   req_valid_i,
  output logic                                  req_ready_o,
  input  wire  [ADDR_WIDTH-1:0]                 req_addr_i,
  input  wire  [DATA_WIDTH-1:0]                 req_wdata_i,
  input  wire  [STRB_WIDTH-1:0]                 req_strb_i,
  input  wire                                   req_we_i,
  output logic                                  rvalid_o,
  output logic [DATA_WIDTH-1:0]                 rdata_o,
  output logic [NUM_BANKS-1:0]                  bank_req_o,
  input  wire  [NUM_BANKS-1:0]                  bank_gnt_i,
  output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]  bank_addr_o,
  output bank_data_t [NUM_BANKS-1:0]            bank_wdata_o,
  output bank_strb_t [NUM_BANKS-1:0]            bank_strb_o,
  output logic [NUM_BANKS-1:0]                  bank_we_o,
  input  wire  [NUM_BANKS-1:0]                  bank_rvalid_i,
  input  wire  bank_data_t [NUM_BANKS-1:0]      bank_rdata_i
);

  logic [ADDR_WIDTH-1:0] base_addr;
  logic                  req_push;
  logic [NUM_BANKS-1:0]  req_held, resp_held, resp_valid;

  assign base_addr   = req_addr_i & ~ADDR_WIDTH'(STRB_WIDTH - 1);
  // Take a request only when no bank still holds an old one.
  assign req_ready_o = ~(|req_held) & ~(|resp_held);
  assign req_push    = req_valid_i & req_ready_o;
  assign rvalid_o    = &resp_valid;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    logic                  req_full_q, resp_full_q, we_q;
    logic [ADDR_WIDTH-1:0] addr_in, addr_q;
    bank_data_t            wdata_q, rdata_q;
    bank_strb_t            strb_q;

    assign addr_in = base_addr + ADDR_WIDTH'(i * BANK_BYTES);

    // Request passes through while empty, stays until granted.
    assign req_held[i]     = req_full_q;
    assign bank_req_o[i]   = req_full_q | req_push;
    assign bank_addr_o[i]  = req_full_q ? addr_q : addr_in;
    assign bank_wdata_o[i] = req_full_q ? wdata_q : req_wdata_i[i*BANK_WIDTH +: BANK_WIDTH];
    assign bank_strb_o[i]  = req_full_q ? strb_q : req_strb_i[i*BANK_BYTES +: BANK_BYTES];
    assign bank_we_o[i]    = req_full_q ? we_q : req_we_i;

    // Response waits here for the slower banks.
    assign resp_held[i]  = resp_full_q;
    assign resp_valid[i] = resp_full_q | bank_rvalid_i[i];
    assign rdata_o[i*BANK_WIDTH +: BANK_WIDTH] = resp_full_q ? rdata_q : bank_rdata_i[i];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        req_full_q  <= 1'b0;
        resp_full_q <= 1'b0;
      end else begin
        req_full_q  <= bank_req_o[i] & ~bank_gnt_i[i];
        resp_full_q <= resp_valid[i] & ~rvalid_o;
      end
    end

    always_ff @(posedge clk_i) begin
      if (req_push) begin
        addr_q  <= addr_in;
        wdata_q <= req_wdata_i[i*BANK_WIDTH +: BANK_WIDTH];
        strb_q  <= req_strb_i[i*BANK_BYTES +: BANK_BYTES];
        we_q    <= req_we_i;
      end
      if (bank_rvalid_i[i] && !resp_full_q) rdata_q <= bank_rdata_i[i];
    end
  end

endmodule

`default_nettype wire

// File: hw/burst_unroll.sv
/*
 * Unrolls an incrementing address-channel burst into single beats.
 * One instance serves reads, one serves writes (WRITE_SIDE set).
 */
`timescale 1ns/100ps
`default_nettype none

module burst_unroll
  import axi_port_pkg::*;
#(
  parameter bit WRITE_SIDE = 1'b0
) (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   ax_valid_i,
  output logic                  ax_ready_o,
  input  wire  [ADDR_WIDTH-1:0] ax_addr_i,
  input  wire  [LEN_WIDTH-1:0]  ax_len_i,
  input  wire  [ID_WIDTH-1:0]   ax_id_i,
  input  wire                   w_valid_i,
  output logic                  beat_valid_o,
  input  wire                   beat_ready_i,
  output logic [ADDR_WIDTH-1:0] beat_addr_o,
  output logic [ID_WIDTH-1:0]   beat_id_o,
  output logic                  beat_last_o,
  output logic                  in_burst_o
);

  burst_state_e          state_q;
  logic [LEN_WIDTH-1:0]  cnt_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic [ADDR_WIDTH-1:0] next_addr;
  logic                  w_ok;
  logic                  beat_fire;

  // Reads have no data to wait for.
  assign w_ok       = WRITE_SIDE ? w_valid_i : 1'b1;
  assign next_addr  = addr_q + ADDR_WIDTH'(WORD_BYTES);
  assign beat_fire  = beat_valid_o & beat_ready_i;
  assign in_burst_o = (state_q == BURST);

  always_comb begin
    if (state_q == IDLE) begin
      // First beat comes straight from the address channel.
      beat_valid_o = ax_valid_i & w_ok;
      beat_addr_o  = ax_addr_i;
      beat_id_o    = ax_id_i;
      beat_last_o  = (ax_len_i == '0);
    end else begin
      beat_valid_o = w_ok;
      beat_addr_o  = next_addr;
      beat_id_o    = id_q;
      beat_last_o  = (cnt_q == LEN_WIDTH'(1));
    end
  end

  // Address handshake happens with the first beat.
  assign ax_ready_o = (state_q == IDLE) & beat_fire;

  // Counter holds the beats still to come.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (beat_fire) begin
      if (state_q == IDLE) begin
        cnt_q <= ax_len_i;
        if (ax_len_i != '0) begin
          state_q <= BURST;
        end
      end else begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == LEN_WIDTH'(1)) begin
          state_q <= IDLE;
        end
      end
    end
  end

  // Stored address is word aligned, later beats step from it.
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      if (state_q == IDLE) begin
        addr_q <= ax_addr_i & ~ADDR_WIDTH'(WORD_BYTES - 1);
        id_q   <= ax_id_i;
      end else begin
        addr_q <= next_addr;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/resp_tracker.sv
/*
 * Keeps issued beats in order and pairs them with memory responses.
 * Credits bound the outstanding beats, so responses never overflow.
 * Paired entries leave on B (last write), R (read), or retire quietly.
 */
`timescale 1ns/100ps
`default_nettype none

module resp_tracker
  import axi_port_pkg::*, bank_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   enq_valid_i,
  output logic                  enq_ready_o,
  input  wire  [ID_WIDTH-1:0]   enq_id_i,
  input  wire                   enq_last_i,
  input  wire                   enq_write_i,
  input  wire                   mem_rvalid_i,
  input  wire  [DATA_WIDTH-1:0] mem_rdata_i,
  output logic                  b_valid_o,
  input  wire                   b_ready_i,
  output logic [ID_WIDTH-1:0]   b_id_o,
  output resp_e                 b_resp_o,
  output logic                  r_valid_o,
  input  wire                   r_ready_i,
  output logic [DATA_WIDTH-1:0] r_data_o,
  output logic [ID_WIDTH-1:0]   r_id_o,
  output logic                  r_last_o,
  output resp_e                 r_resp_o,
  output logic                  busy_o
);

  // Metadata FIFO.
  logic [ID_WIDTH-1:0]    meta_id_q    [TRACK_DEPTH];
  logic                   meta_last_q  [TRACK_DEPTH];
  logic                   meta_write_q [TRACK_DEPTH];
  logic [TRACK_PTR_W-1:0] mwr_ptr_q, mrd_ptr_q;
  logic [TRACK_CNT_W-1:0] mcnt_q;
  // Response data FIFO and credits.
  logic [DATA_WIDTH-1:0]  data_q [BUF_DEPTH];
  logic [BUF_PTR_W-1:0]   dwr_ptr_q, drd_ptr_q;
  logic [BUF_CNT_W-1:0]   dcnt_q, credit_q;
  logic                   enq_fire, head_valid, head_write, head_last, pop;

  function automatic logic [TRACK_PTR_W-1:0] track_next(input logic [TRACK_PTR_W-1:0] p);
    return (p == TRACK_PTR_W'(TRACK_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic logic [BUF_PTR_W-1:0] buf_next(input logic [BUF_PTR_W-1:0] p);
    return (p == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Accept a beat only with room for its metadata and its response.
  assign enq_ready_o = (mcnt_q != TRACK_CNT_W'(TRACK_DEPTH)) & (credit_q != '0);
  assign enq_fire    = enq_valid_i & enq_ready_o;

  // Head of both FIFOs forms one response.
  assign head_valid = (mcnt_q != '0) & (dcnt_q != '0);
  assign head_write = meta_write_q[mrd_ptr_q];
  assign head_last  = meta_last_q[mrd_ptr_q];

  assign b_valid_o = head_valid & head_write & head_last;
  assign b_id_o    = meta_id_q[mrd_ptr_q];
  assign b_resp_o  = RESP_OKAY;
  assign r_valid_o = head_valid & ~head_write;
  assign r_data_o  = data_q[drd_ptr_q];
  assign r_id_o    = meta_id_q[mrd_ptr_q];
  assign r_last_o  = head_last;
  assign r_resp_o  = RESP_OKAY;

  // Inner write beats leave without a channel handshake.
  assign pop    = head_valid & (head_write ? (~head_last | b_ready_i) : r_ready_i);
  assign busy_o = (mcnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mwr_ptr_q <= '0;
      mrd_ptr_q <= '0;
      mcnt_q    <= '0;
      dwr_ptr_q <= '0;
      drd_ptr_q <= '0;
      dcnt_q    <= '0;
      credit_q  <= BUF_CNT_W'(BUF_DEPTH);
    end else begin
      if (enq_fire) mwr_ptr_q <= track_next(mwr_ptr_q);
      if (mem_rvalid_i) dwr_ptr_q <= buf_next(dwr_ptr_q);
      if (pop) begin
        mrd_ptr_q <= track_next(mrd_ptr_q);
        drd_ptr_q <= buf_next(drd_ptr_q);
      end
      mcnt_q   <= mcnt_q + TRACK_CNT_W'(enq_fire) - TRACK_CNT_W'(pop);
      dcnt_q   <= dcnt_q + BUF_CNT_W'(mem_rvalid_i) - BUF_CNT_W'(pop);
      // A credit returns when its response leaves the buffer.
      credit_q <= credit_q - BUF_CNT_W'(enq_fire) + BUF_CNT_W'(pop);
    end
  end

  // FIFO storage.
  always_ff @(posedge clk_i) begin
    if (enq_fire) begin
      meta_id_q[mwr_ptr_q]    <= enq_id_i;
      meta_last_q[mwr_ptr_q]  <= enq_last_i;
      meta_write_q[mwr_ptr_q] <= enq_write_i;
    end
    if (mem_rvalid_i) data_q[dwr_ptr_q] <= mem_rdata_i;
  end

endmodule

`default_nettype wire

// File: hw/rw_arbiter.sv
/*
 * Picks the read or the write beat stream for the memory side.
 * Selection is combinational and held while the output stalls.
 */
`timescale 1ns/100ps
`default_nettype none

module rw_arbiter
  import axi_port_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   rd_valid_i,
  output logic                  rd_ready_o,
  input  wire  [ADDR_WIDTH-1:0] rd_addr_i,
  input  wire  [ID_WIDTH-1:0]   rd_id_i,
  input  wire                   rd_last_i,
  input  wire                   rd_in_burst_i,
  input  wire                   wr_valid_i,
  output logic                  wr_ready_o,
  input  wire  [ADDR_WIDTH-1:0] wr_addr_i,
  input  wire  [ID_WIDTH-1:0]   wr_id_i,
  input  wire                   wr_last_i,
  input  wire                   wr_in_burst_i,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output logic [ADDR_WIDTH-1:0] out_addr_o,
  output logic [ID_WIDTH-1:0]   out_id_o,
  output logic                  out_last_o,
  output logic                  out_write_o
);

  // High selects the write side.
  logic sel;
  logic sel_q;
  logic lock_q;

  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        // Single or closing write beats go ahead of read bursts.
        if (wr_last_i && !rd_last_i) sel = 1'b1;
        // Then finish whatever burst is already running.
        else if (wr_in_burst_i) sel = 1'b1;
        else if (rd_in_burst_i) sel = 1'b0;
        // Otherwise take turns.
        else sel = ~sel_q;
      end
    end
  end

  assign out_valid_o = sel ? wr_valid_i : rd_valid_i;
  assign out_addr_o  = sel ? wr_addr_i : rd_addr_i;
  assign out_id_o    = sel ? wr_id_i : rd_id_i;
  assign out_last_o  = sel ? wr_last_i : rd_last_i;
  assign out_write_o = sel;
  assign wr_ready_o  = sel & out_ready_i;
  assign rd_ready_o  = ~sel & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q <= sel;
      // Hold the choice from a stalled offer until it transfers.
      if (lock_q) begin
        if (out_valid_o && out_ready_i) lock_q <= 1'b0;
      end else if (out_valid_o && !out_ready_i) begin
        lock_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
hw/axi_port_pkg.sv
hw/bank_pkg.sv
hw/burst_unroll.sv
hw/rw_arbiter.sv
hw/resp_tracker.sv
hw/bank_split.sv
hw/axi_mem_top.sv
bench/bank_model.sv
bench/tb_axi_mem_top.sv
